/* rtl/rv32_isa_pkg.sv */
// rv32i isa types, alu and operand-select enums, branch funct3 enum, immediate decoders
package rv32_isa_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] data_t;

    // r-type field layout, enough to reach funct3
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_t;

    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_or   = 4'h3,
        alu_xor  = 4'h4,
        alu_slt  = 4'h5,
        alu_sltu = 4'h6,
        alu_sll  = 4'h7,
        alu_srl  = 4'h8,
        alu_sra  = 4'h9
    } alu_func_e;

    typedef enum logic [1:0] {
        opa_rs1  = 2'd0,
        opa_npc  = 2'd1,
        opa_pc   = 2'd2,
        opa_zero = 2'd3
    } opa_select_e;

    typedef enum logic [2:0] {
        opb_rs2   = 3'd0,
        opb_i_imm = 3'd1,
        opb_s_imm = 3'd2,
        opb_b_imm = 3'd3,
        opb_u_imm = 3'd4,
        opb_j_imm = 3'd5
    } opb_select_e;

    // riscv funct3 codes of the conditional branches
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_func_e;

    function automatic data_t imm_i(inst_t inst);
        logic [31:0] w;
        w = inst;
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic data_t imm_s(inst_t inst);
        logic [31:0] w;
        w = inst;
        return {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    // branch offsets are halfword aligned, bit 0 always zero
    function automatic data_t imm_b(inst_t inst);
        logic [31:0] w;
        w = inst;
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic data_t imm_u(inst_t inst);
        logic [31:0] w;
        w = inst;
        return {w[31:12], 12'b0};
    endfunction

    function automatic data_t imm_j(inst_t inst);
        logic [31:0] w;
        w = inst;
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

endpackage

/* rtl/exec_pkg.sv */
// execute-cluster sizes, rob tag type and functional-unit index type
package exec_pkg;

    // alu units sharing the cdb
    localparam int num_alu_fu = 2;

    // rob depth 32
    localparam int rob_tag_bits = 5;

    typedef logic [rob_tag_bits-1:0] rob_tag_t;

    // one bit is enough for two units
    typedef logic [$clog2(num_alu_fu)-1:0] fu_index_t;

endpackage

/* rtl/exec_ifs.sv */
// interfaces fu_issue_if and fu_result_if with their modports
`timescale 1ns/1ps

interface fu_issue_if;
    import rv32_isa_pkg::*;
    import exec_pkg::*;

    // issue strobe, only while ready
    logic        issue_valid;
    inst_t       inst;
    data_t       rs1_value;
    data_t       rs2_value;
    data_t       pc;
    data_t       npc;
    opa_select_e opa_select;
    opb_select_e opb_select;
    alu_func_e   alu_func;
    rob_tag_t    rob_tag;
    // unit can take an issue this cycle
    logic        ready;

    modport issuer (
        output issue_valid, inst, rs1_value, rs2_value, pc, npc,
        output opa_select, opb_select, alu_func, rob_tag,
        input  ready
    );

    modport fu (
        input  issue_valid, inst, rs1_value, rs2_value, pc, npc,
        input  opa_select, opb_select, alu_func, rob_tag,
        output ready
    );

endinterface

interface fu_result_if;
    import rv32_isa_pkg::*;
    import exec_pkg::*;

    logic     done;
    data_t    value;
    rob_tag_t rob_tag;
    logic     take_branch;
    // result retired on the cdb this cycle
    logic     ack;

    modport fu_side (
        output done, value, rob_tag, take_branch,
        input  ack
    );

    modport arb_side (
        input  done, value, rob_tag, take_branch,
        output ack
    );

endinterface

/* rtl/alu.sv */
// combinational rv32i integer alu
`timescale 1ns/1ps

module alu (
    input  rv32_isa_pkg::data_t     opa,
    input  rv32_isa_pkg::data_t     opb,
    input  rv32_isa_pkg::alu_func_e func,
    output rv32_isa_pkg::data_t     result
);
    import rv32_isa_pkg::*;

    // signed views for slt and sra
    logic signed [xlen-1:0] signed_opa;
    logic signed [xlen-1:0] signed_opb;
    // shift amount, low five bits only
    logic [4:0]             shamt;

    assign signed_opa = opa;
    assign signed_opb = opb;
    assign shamt      = opb[4:0];

    always_comb begin
        case (func)
            alu_add:  result = opa + opb;
            alu_sub:  result = opa - opb;
            alu_and:  result = opa & opb;
            alu_or:   result = opa | opb;
            alu_xor:  result = opa ^ opb;
            // compare results land in bit 0
            alu_slt:  result = {{(xlen-1){1'b0}}, signed_opa < signed_opb};
            alu_sltu: result = {{(xlen-1){1'b0}}, opa < opb};
            alu_sll:  result = opa << shamt;
            alu_srl:  result = opa >> shamt;
            // arithmetic shift keeps the sign
            alu_sra:  result = signed_opa >>> shamt;
            default:  result = '0;
        endcase
    end

endmodule

/* rtl/branch_condition.sv */
// combinational evaluation of the six rv32i conditional branch comparisons
`timescale 1ns/1ps

module branch_condition (
    input  rv32_isa_pkg::branch_func_e func,
    input  rv32_isa_pkg::data_t        rs1,
    input  rv32_isa_pkg::data_t        rs2,
    output logic                       take
);
    import rv32_isa_pkg::*;

    logic signed [xlen-1:0] signed_rs1;
    logic signed [xlen-1:0] signed_rs2;

    assign signed_rs1 = rs1;
    assign signed_rs2 = rs2;

    always_comb begin
        case (func)
            br_beq:  take = rs1 == rs2;
            br_bne:  take = rs1 != rs2;
            // signed compares
            br_blt:  take = signed_rs1 < signed_rs2;
            br_bge:  take = signed_rs1 >= signed_rs2;
            // unsigned compares
            br_bltu: take = rs1 < rs2;
            br_bgeu: take = rs1 >= rs2;
            // funct3 010 and 011 are not branches
            default: take = 1'b0;
        endcase
    end

endmodule

/* rtl/alu_fu.sv */
// alu functional unit: operand muxes, alu, branch condition, result hold with done/ack
`timescale 1ns/1ps

module alu_fu (
    input logic        clock,
    input logic        reset,
    fu_issue_if.fu     issue,
    fu_result_if.fu_side result
);
    import rv32_isa_pkg::*;
    import exec_pkg::*;

    data_t    opa_mux_out;
    data_t    opb_mux_out;
    data_t    alu_result;
    logic     take_conditional;

    // hold register
    logic     done_q;
    data_t    value_q;
    rob_tag_t rob_tag_q;
    logic     take_q;

    // operand a source
    always_comb begin
        case (issue.opa_select)
            opa_rs1:  opa_mux_out = issue.rs1_value;
            opa_npc:  opa_mux_out = issue.npc;
            opa_pc:   opa_mux_out = issue.pc;
            opa_zero: opa_mux_out = '0;
            default:  opa_mux_out = '0;
        endcase
    end

    // operand b source, immediates decoded from the instruction word
    always_comb begin
        case (issue.opb_select)
            opb_rs2:   opb_mux_out = issue.rs2_value;
            opb_i_imm: opb_mux_out = imm_i(issue.inst);
            opb_s_imm: opb_mux_out = imm_s(issue.inst);
            opb_b_imm: opb_mux_out = imm_b(issue.inst);
            opb_u_imm: opb_mux_out = imm_u(issue.inst);
            opb_j_imm: opb_mux_out = imm_j(issue.inst);
            // unused select codes, easy to spot in waves
            default:   opb_mux_out = 32'hfacefeed;
        endcase
    end

    alu u_alu (
        .opa    (opa_mux_out),
        .opb    (opb_mux_out),
        .func   (issue.alu_func),
        .result (alu_result)
    );

    // branch compare always on the register values
    branch_condition u_branch_condition (
        .func (branch_func_e'(issue.inst.funct3)),
        .rs1  (issue.rs1_value),
        .rs2  (issue.rs2_value),
        .take (take_conditional)
    );

    // done set by issue, cleared by ack; a reissue in the ack cycle wins
    always_ff @(posedge clock) begin
        if (reset) begin
            done_q <= 1'b0;
        end else if (issue.issue_valid) begin
            done_q <= 1'b1;
        end else if (result.ack) begin
            done_q <= 1'b0;
        end
    end

    // payload only loads on issue, so a held result stays put until ack
    always_ff @(posedge clock) begin
        if (issue.issue_valid) begin
            value_q   <= alu_result;
            rob_tag_q <= issue.rob_tag;
            take_q    <= take_conditional;
        end
    end

    // free when empty or retiring this cycle
    assign issue.ready        = !done_q || result.ack;

    assign result.done        = done_q;
    assign result.value       = value_q;
    assign result.rob_tag     = rob_tag_q;
    assign result.take_branch = take_q;

endmodule

/* rtl/cdb_arbiter.sv */
// round-robin cdb arbiter with ack generation and cdb output mux
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                 clock,
    input  logic                 reset,
    fu_result_if.arb_side        fu [exec_pkg::num_alu_fu],
    input  logic                 cdb_ready,
    output logic                 cdb_valid,
    output rv32_isa_pkg::data_t  cdb_value,
    output exec_pkg::rob_tag_t   cdb_rob_tag,
    output logic                 cdb_take_branch,
    output exec_pkg::fu_index_t  cdb_fu
);
    import rv32_isa_pkg::*;
    import exec_pkg::*;

    // flattened view of the unit interfaces
    logic [num_alu_fu-1:0] done_vec;
    logic [num_alu_fu-1:0] ack_vec;
    data_t                 value_vec [num_alu_fu];
    rob_tag_t              tag_vec   [num_alu_fu];
    logic [num_alu_fu-1:0] take_vec;

    // priority pointer and current pick
    fu_index_t             ptr;
    fu_index_t             grant_idx;
    logic                  found;

    for (genvar i = 0; i < num_alu_fu; i++) begin : g_unpack
        assign done_vec[i]  = fu[i].done;
        assign value_vec[i] = fu[i].value;
        assign tag_vec[i]   = fu[i].rob_tag;
        assign take_vec[i]  = fu[i].take_branch;
        assign fu[i].ack    = ack_vec[i];
    end

    // first done unit at or after the pointer
    always_comb begin
        int cand;
        found     = 1'b0;
        grant_idx = ptr;
        for (int k = 0; k < num_alu_fu; k++) begin
            cand = (int'(ptr) + k) % num_alu_fu;
            if (!found && done_vec[cand]) begin
                found     = 1'b1;
                grant_idx = fu_index_t'(cand);
            end
        end
    end

    assign cdb_valid = cdb_ready && found;

    // one-hot ack, none under back-pressure
    always_comb begin
        ack_vec = '0;
        if (cdb_valid) begin
            ack_vec[grant_idx] = 1'b1;
        end
    end

    assign cdb_value       = value_vec[grant_idx];
    assign cdb_rob_tag     = tag_vec[grant_idx];
    assign cdb_take_branch = take_vec[grant_idx];
    assign cdb_fu          = grant_idx;

    // step past the granted unit, wrap at the last
    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else if (cdb_valid) begin
            if (grant_idx == fu_index_t'(num_alu_fu - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= grant_idx + 1'b1;
            end
        end
    end

endmodule

/* rtl/alu_exec_cluster.sv */
// integer execute cluster top: alu units, cdb arbiter and interface wiring
`timescale 1ns/1ps

module alu_exec_cluster (
    input  logic                        clock,
    input  logic                        reset,

    // issue side, one entry per unit
    input  logic [exec_pkg::num_alu_fu-1:0] issue_valid,
    input  rv32_isa_pkg::inst_t         issue_inst       [exec_pkg::num_alu_fu],
    input  rv32_isa_pkg::data_t         issue_rs1_value  [exec_pkg::num_alu_fu],
    input  rv32_isa_pkg::data_t         issue_rs2_value  [exec_pkg::num_alu_fu],
    input  rv32_isa_pkg::data_t         issue_pc         [exec_pkg::num_alu_fu],
    input  rv32_isa_pkg::data_t         issue_npc        [exec_pkg::num_alu_fu],
    input  rv32_isa_pkg::opa_select_e   issue_opa_select [exec_pkg::num_alu_fu],
    input  rv32_isa_pkg::opb_select_e   issue_opb_select [exec_pkg::num_alu_fu],
    input  rv32_isa_pkg::alu_func_e     issue_alu_func   [exec_pkg::num_alu_fu],
    input  exec_pkg::rob_tag_t          issue_rob_tag    [exec_pkg::num_alu_fu],
    output logic [exec_pkg::num_alu_fu-1:0] fu_ready,

    // common data bus
    input  logic                        cdb_ready,
    output logic                        cdb_valid,
    output rv32_isa_pkg::data_t         cdb_value,
    output exec_pkg::rob_tag_t          cdb_rob_tag,
    output logic                        cdb_take_branch,
    output exec_pkg::fu_index_t         cdb_fu
);
    import exec_pkg::*;

    fu_issue_if  issue_bus  [num_alu_fu] ();
    fu_result_if result_bus [num_alu_fu] ();

    for (genvar i = 0; i < num_alu_fu; i++) begin : g_fu
        // top level plays the issuer side of each issue bus
        assign issue_bus[i].issue_valid = issue_valid[i];
        assign issue_bus[i].inst        = issue_inst[i];
        assign issue_bus[i].rs1_value   = issue_rs1_value[i];
        assign issue_bus[i].rs2_value   = issue_rs2_value[i];
        assign issue_bus[i].pc          = issue_pc[i];
        assign issue_bus[i].npc         = issue_npc[i];
        assign issue_bus[i].opa_select  = issue_opa_select[i];
        assign issue_bus[i].opb_select  = issue_opb_select[i];
        assign issue_bus[i].alu_func    = issue_alu_func[i];
        assign issue_bus[i].rob_tag     = issue_rob_tag[i];
        assign fu_ready[i]              = issue_bus[i].ready;

        alu_fu u_alu_fu (
            .clock  (clock),
            .reset  (reset),
            .issue  (issue_bus[i]),
            .result (result_bus[i])
        );
    end

    // one result per cycle onto the cdb
    cdb_arbiter u_cdb_arbiter (
        .clock           (clock),
        .reset           (reset),
        .fu              (result_bus),
        .cdb_ready       (cdb_ready),
        .cdb_valid       (cdb_valid),
        .cdb_value       (cdb_value),
        .cdb_rob_tag     (cdb_rob_tag),
        .cdb_take_branch (cdb_take_branch),
        .cdb_fu          (cdb_fu)
    );

endmodule

/* verification/alu_exec_cluster_props.sv */
// concurrent assertions on the execute cluster handshakes, plus the bind into alu_exec_cluster
`timescale 1ns/1ps

module alu_exec_cluster_props (
    input logic                              clock,
    input logic                              reset,
    input logic [exec_pkg::num_alu_fu-1:0]   issue_valid,
    input logic [exec_pkg::num_alu_fu-1:0]   fu_ready,
    input logic [exec_pkg::num_alu_fu-1:0]   done,
    input logic [exec_pkg::num_alu_fu-1:0]   ack,
    input logic                              cdb_ready,
    input logic                              cdb_valid,
    input rv32_isa_pkg::data_t               value [exec_pkg::num_alu_fu]
);
    import exec_pkg::*;

    // running count of assertion failures
    int failures = 0;

    // issuer must respect ready
    issue_only_when_ready: assert property (@(posedge clock) disable iff (reset)
        (issue_valid & ~fu_ready) == '0)
        else begin
            $error("issue_valid high on a unit whose ready is low");
            failures++;
        end

    ack_only_when_done: assert property (@(posedge clock) disable iff (reset)
        (ack & ~done) == '0)
        else begin
            $error("ack given to a unit that is not done");
            failures++;
        end

    // no broadcast under back-pressure
    no_valid_without_ready: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> cdb_ready)
        else begin
            $error("cdb_valid high while cdb_ready is low");
            failures++;
        end

    single_ack: assert property (@(posedge clock) disable iff (reset)
        $onehot0(ack))
        else begin
            $error("more than one ack in a cycle");
            failures++;
        end

    // held result frozen until retired
    for (genvar i = 0; i < num_alu_fu; i++) begin : g_hold
        value_held: assert property (@(posedge clock) disable iff (reset)
            done[i] && !ack[i] |=> $stable(value[i]))
            else begin
                $error("held value of unit %0d changed before ack", i);
                failures++;
            end
    end

endmodule

bind alu_exec_cluster alu_exec_cluster_props u_props (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .fu_ready    (fu_ready),
    .done        (u_cdb_arbiter.done_vec),
    .ack         (u_cdb_arbiter.ack_vec),
    .cdb_ready   (cdb_ready),
    .cdb_valid   (cdb_valid),
    .value       (u_cdb_arbiter.value_vec)
);

/* verification/alu_exec_cluster_tb.sv */
// testbench for alu_exec_cluster with stimulus table, reference model, cdb scoreboard, watchdog
`timescale 1ns/1ps

module alu_exec_cluster_tb;
    import rv32_isa_pkg::*;
    import exec_pkg::*;

    typedef struct {
        int          unit;
        data_t       rs1;
        data_t       rs2;
        data_t       pc;
        data_t       npc;
        logic [31:0] inst;
        opa_select_e opa_sel;
        opb_select_e opb_sel;
        alu_func_e   func;
        rob_tag_t    tag;
        // cdb_ready per cycle from the issue cycle on with lsb first
        logic [7:0]  pattern;
        data_t       exp_value;
        logic        exp_take;
    } entry_t;

    logic                  clock;
    logic                  reset;
    logic [num_alu_fu-1:0] issue_valid;
    inst_t                 issue_inst       [num_alu_fu];
    data_t                 issue_rs1_value  [num_alu_fu];
    data_t                 issue_rs2_value  [num_alu_fu];
    data_t                 issue_pc         [num_alu_fu];
    data_t                 issue_npc        [num_alu_fu];
    opa_select_e           issue_opa_select [num_alu_fu];
    opb_select_e           issue_opb_select [num_alu_fu];
    alu_func_e             issue_alu_func   [num_alu_fu];
    rob_tag_t              issue_rob_tag    [num_alu_fu];
    logic [num_alu_fu-1:0] fu_ready;
    logic                  cdb_ready;
    logic                  cdb_valid;
    data_t                 cdb_value;
    rob_tag_t              cdb_rob_tag;
    logic                  cdb_take_branch;
    fu_index_t             cdb_fu;

    entry_t     entries [$];
    logic [7:0] ready_shift;
    int         checks;
    int         errors;
    bit         table_built;

    // scoreboard by rob tag
    logic [2**rob_tag_bits-1:0] tag_pending;
    data_t                      exp_value_by_tag [2**rob_tag_bits];
    logic                       exp_take_by_tag  [2**rob_tag_bits];

    // model of the hold registers and the priority pointer
    logic [num_alu_fu-1:0] held;
    rob_tag_t              held_tag [num_alu_fu];
    int                    rr_ptr;

    alu_exec_cluster dut (
        .clock            (clock),
        .reset            (reset),
        .issue_valid      (issue_valid),
        .issue_inst       (issue_inst),
        .issue_rs1_value  (issue_rs1_value),
        .issue_rs2_value  (issue_rs2_value),
        .issue_pc         (issue_pc),
        .issue_npc        (issue_npc),
        .issue_opa_select (issue_opa_select),
        .issue_opb_select (issue_opb_select),
        .issue_alu_func   (issue_alu_func),
        .issue_rob_tag    (issue_rob_tag),
        .fu_ready         (fu_ready),
        .cdb_ready        (cdb_ready),
        .cdb_valid        (cdb_valid),
        .cdb_value        (cdb_value),
        .cdb_rob_tag      (cdb_rob_tag),
        .cdb_take_branch  (cdb_take_branch),
        .cdb_fu           (cdb_fu)
    );

    // 8 ns period
    always #4 clock = ~clock;

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0.0f ns: %s", $realtime, msg);
    endtask

    task automatic check_data(input data_t actual, input data_t expected, input string what);
        checks++;
        if (actual !== expected)
            report_error($sformatf("%s is %h, expected %h", what, actual, expected));
    endtask

    task automatic check_tag(input rob_tag_t actual, input rob_tag_t expected, input string what);
        checks++;
        if (actual !== expected)
            report_error($sformatf("%s is %0d, expected %0d", what, actual, expected));
    endtask

    task automatic check_take(input logic actual, input logic expected, input string what);
        checks++;
        if (actual !== expected)
            report_error($sformatf("%s is %b, expected %b", what, actual, expected));
    endtask

    task automatic check_fu(input fu_index_t actual, input fu_index_t expected, input string what);
        checks++;
        if (actual !== expected)
            report_error($sformatf("%s is %0d, expected %0d", what, actual, expected));
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        checks++;
        if (actual !== expected)
            report_error($sformatf("%s is %b, expected %b", what, actual, expected));
    endtask

    function automatic data_t ref_opa(input opa_select_e sel, input data_t rs1, input data_t pc,
                                      input data_t npc);
        case (sel)
            opa_npc:  return npc;
            opa_pc:   return pc;
            opa_zero: return 32'h0;
            default:  return rs1;
        endcase
    endfunction

    // riscv immediate layouts with the sign taken from inst[31]
    function automatic data_t ref_opb(input opb_select_e sel, input logic [31:0] w,
                                      input data_t rs2);
        logic signed [11:0] imm12;
        logic signed [12:0] imm13;
        logic signed [20:0] imm21;
        data_t              r;
        r = rs2;
        case (sel)
            opb_i_imm: begin
                imm12 = w[31:20];
                r = imm12;
            end
            opb_s_imm: begin
                imm12 = {w[31:25], w[11:7]};
                r = imm12;
            end
            opb_b_imm: begin
                imm13 = {w[31], w[7], w[30:25], w[11:8], 1'b0};
                r = imm13;
            end
            opb_u_imm: r = {w[31:12], 12'h000};
            opb_j_imm: begin
                imm21 = {w[31], w[19:12], w[20], w[30:21], 1'b0};
                r = imm21;
            end
            default: r = rs2;
        endcase
        return r;
    endfunction

    function automatic data_t ref_alu(input alu_func_e f, input data_t a, input data_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f)
            alu_add:  return a + b;
            alu_sub:  return a + ~b + 32'h1;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            // differing signs decide the signed compare
            alu_slt:  return (a[31] != b[31]) ? data_t'(a[31]) : data_t'(a < b);
            alu_sltu: return data_t'(a < b);
            alu_sll:  return a << sh;
            alu_srl:  return a >> sh;
            // sign fill of the vacated upper bits
            alu_sra:  return (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'h0);
            default:  return 32'h0;
        endcase
    endfunction

    function automatic logic ref_take(input logic [31:0] w, input data_t rs1, input data_t rs2);
        logic lt;
        lt = (rs1[31] != rs2[31]) ? rs1[31] : (rs1 < rs2);
        case (w[14:12])
            3'b000:  return rs1 == rs2;
            3'b001:  return rs1 != rs2;
            3'b100:  return lt;
            3'b101:  return !lt;
            3'b110:  return rs1 < rs2;
            3'b111:  return rs1 >= rs2;
            default: return 1'b0;
        endcase
    endfunction

    // units alternate by table position and the tag is the table index
    function automatic void add_entry(input alu_func_e func, input opa_select_e opa_sel,
                                      input opb_select_e opb_sel, input data_t rs1,
                                      input data_t rs2, input logic [31:0] inst,
                                      input logic [7:0] pattern);
        entry_t e;
        e.unit      = entries.size() % num_alu_fu;
        e.rs1       = rs1;
        e.rs2       = rs2;
        e.pc        = 32'h00001000 + 32'(4 * entries.size());
        e.npc       = e.pc + 32'h4;
        e.inst      = inst;
        e.opa_sel   = opa_sel;
        e.opb_sel   = opb_sel;
        e.func      = func;
        e.tag       = rob_tag_t'(entries.size());
        e.pattern   = pattern;
        e.exp_value = ref_alu(func, ref_opa(opa_sel, rs1, e.pc, e.npc),
                              ref_opb(opb_sel, inst, rs2));
        e.exp_take  = ref_take(inst, rs1, rs2);
        entries.push_back(e);
    endfunction

    function automatic void build_table();
        // alu corners on register operands
        add_entry(alu_add,  opa_rs1, opb_rs2, 32'h7fffffff, 32'h00000001, 32'h33, 8'hff);
        add_entry(alu_sub,  opa_rs1, opb_rs2, 32'h00000000, 32'h00000001, 32'h33, 8'hff);
        add_entry(alu_and,  opa_rs1, opb_rs2, 32'hffff0000, 32'h0f0f0f0f, 32'h33, 8'hff);
        add_entry(alu_or,   opa_rs1, opb_rs2, 32'h80000000, 32'h0000ffff, 32'h33, 8'hff);
        add_entry(alu_xor,  opa_rs1, opb_rs2, 32'haaaaaaaa, 32'hffffffff, 32'h33, 8'hff);
        add_entry(alu_slt,  opa_rs1, opb_rs2, 32'h80000000, 32'h00000001, 32'h33, 8'hff);
        add_entry(alu_sltu, opa_rs1, opb_rs2, 32'h80000000, 32'h00000001, 32'h33, 8'hff);
        add_entry(alu_sll,  opa_rs1, opb_rs2, 32'h12345678, 32'hffffffe0, 32'h33, 8'hff);
        add_entry(alu_sll,  opa_rs1, opb_rs2, 32'h00000001, 32'h0000001f, 32'h33, 8'hff);
        add_entry(alu_srl,  opa_rs1, opb_rs2, 32'h80000000, 32'h0000001f, 32'h33, 8'hff);
        add_entry(alu_sra,  opa_rs1, opb_rs2, 32'h80000000, 32'h0000001f, 32'h33, 8'hff);
        add_entry(alu_sra,  opa_rs1, opb_rs2, 32'h7fff0000, 32'h00000020, 32'h33, 8'hff);
        // operand sources and immediate forms
        add_entry(alu_add, opa_npc,  opb_i_imm, 32'h0, 32'h0, 32'hfff00013, 8'hff);
        add_entry(alu_add, opa_rs1,  opb_i_imm, 32'h100, 32'h0, 32'h7ff00013, 8'hff);
        add_entry(alu_add, opa_pc,   opb_u_imm, 32'h0, 32'h0, 32'h12345017, 8'hff);
        add_entry(alu_add, opa_zero, opb_u_imm, 32'hdeadbeef, 32'h0, 32'hfffff037, 8'hff);
        add_entry(alu_add, opa_rs1,  opb_s_imm, 32'h2000, 32'h0, 32'hfe112c23, 8'hff);
        add_entry(alu_add, opa_pc,   opb_b_imm, 32'h5, 32'h5, 32'hfe208ee3, 8'hff);
        add_entry(alu_add, opa_pc,   opb_j_imm, 32'h0, 32'h0, 32'h800000ef, 8'hff);
        // the six branches plus one non-branch funct3
        add_entry(alu_add, opa_pc, opb_b_imm, 32'h1234, 32'h1234, 32'h00208463, 8'hff);
        add_entry(alu_add, opa_pc, opb_b_imm, 32'h1234, 32'h1234, 32'h00209463, 8'hff);
        add_entry(alu_add, opa_pc, opb_b_imm, 32'hffffffff, 32'h1, 32'h0020c463, 8'hff);
        add_entry(alu_add, opa_pc, opb_b_imm, 32'hffffffff, 32'h1, 32'h0020d463, 8'hff);
        add_entry(alu_add, opa_pc, opb_b_imm, 32'hffffffff, 32'h1, 32'h0020e463, 8'hff);
        add_entry(alu_add, opa_pc, opb_b_imm, 32'hffffffff, 32'h1, 32'h0020f463, 8'hff);
        add_entry(alu_add, opa_pc, opb_b_imm, 32'h1, 32'h2, 32'h0020a463, 8'hff);
        // back-pressure with cdb_ready low for eight cycles each
        add_entry(alu_add, opa_rs1, opb_rs2, 32'h11111111, 32'h22222222, 32'h33, 8'h00);
        add_entry(alu_xor, opa_rs1, opb_rs2, 32'h33333333, 32'h0f0f0f0f, 32'h33, 8'h00);
        // random fill
        repeat (4) begin
            add_entry(alu_func_e'($urandom_range(9, 0)), opa_select_e'($urandom_range(3, 0)),
                      opb_select_e'($urandom_range(5, 0)), $urandom(), $urandom(), $urandom(),
                      8'hff);
        end
    endfunction

    task automatic drive_cycle(input bit do_issue, input int idx);
        int u;
        @(posedge clock);
        #1;
        issue_valid = '0;
        if (do_issue) begin
            u = entries[idx].unit;
            issue_inst[u]       = entries[idx].inst;
            issue_rs1_value[u]  = entries[idx].rs1;
            issue_rs2_value[u]  = entries[idx].rs2;
            issue_pc[u]         = entries[idx].pc;
            issue_npc[u]        = entries[idx].npc;
            issue_opa_select[u] = entries[idx].opa_sel;
            issue_opb_select[u] = entries[idx].opb_sel;
            issue_alu_func[u]   = entries[idx].func;
            issue_rob_tag[u]    = entries[idx].tag;
            issue_valid[u]      = 1'b1;
            held_tag[u]         = entries[idx].tag;
            tag_pending[entries[idx].tag]      = 1'b1;
            exp_value_by_tag[entries[idx].tag] = entries[idx].exp_value;
            exp_take_by_tag[entries[idx].tag]  = entries[idx].exp_take;
            ready_shift = entries[idx].pattern;
        end
        cdb_ready   = ready_shift[0];
        ready_shift = {1'b1, ready_shift[7:1]};
    endtask

    // cdb monitor samples mid-cycle once everything has settled
    always @(negedge clock) begin
        int   grant;
        logic exp_valid;
        if (!reset) begin
            grant = -1;
            for (int k = 0; k < num_alu_fu; k++) begin
                if (grant < 0 && held[(rr_ptr + k) % num_alu_fu])
                    grant = (rr_ptr + k) % num_alu_fu;
            end
            exp_valid = cdb_ready && grant >= 0;
            check_flag(cdb_valid, exp_valid, "cdb_valid");
            for (int u = 0; u < num_alu_fu; u++) begin
                check_flag(fu_ready[u], !held[u] || (exp_valid && grant == u),
                           $sformatf("fu_ready[%0d]", u));
            end
            if (cdb_valid && exp_valid) begin
                check_fu(cdb_fu, fu_index_t'(grant), "cdb_fu");
                check_tag(cdb_rob_tag, held_tag[grant], "cdb_rob_tag");
                if (!tag_pending[cdb_rob_tag]) begin
                    report_error($sformatf("broadcast of tag %0d, not in flight", cdb_rob_tag));
                end else begin
                    check_data(cdb_value, exp_value_by_tag[cdb_rob_tag], "cdb_value");
                    check_take(cdb_take_branch, exp_take_by_tag[cdb_rob_tag], "cdb_take_branch");
                    tag_pending[cdb_rob_tag] = 1'b0;
                end
            end
            // model state for the next cycle
            if (exp_valid) begin
                held[grant] = 1'b0;
                rr_ptr = (grant + 1) % num_alu_fu;
            end
            held = held | issue_valid;
        end
    end

    initial begin
        bit free;
        void'($urandom(32'hf3857cb6));
        clock       = 1'b0;
        reset       = 1'b1;
        issue_valid = '0;
        cdb_ready   = 1'b1;
        ready_shift = 8'hff;
        for (int u = 0; u < num_alu_fu; u++) begin
            issue_inst[u]       = '0;
            issue_rs1_value[u]  = '0;
            issue_rs2_value[u]  = '0;
            issue_pc[u]         = '0;
            issue_npc[u]        = '0;
            issue_opa_select[u] = opa_rs1;
            issue_opb_select[u] = opb_rs2;
            issue_alu_func[u]   = alu_add;
            issue_rob_tag[u]    = '0;
            held_tag[u]         = '0;
        end
        tag_pending = '0;
        held        = '0;
        rr_ptr      = 0;
        checks      = 0;
        errors      = 0;
        build_table();
        table_built = 1'b1;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        foreach (entries[e]) begin
            // unit free next cycle if ready now and not just issued
            free = 1'b0;
            while (!free) begin
                @(negedge clock);
                free = fu_ready[entries[e].unit] && !issue_valid[entries[e].unit];
                if (!free)
                    drive_cycle(1'b0, 0);
            end
            drive_cycle(1'b1, e);
        end
        while (tag_pending != '0)
            drive_cycle(1'b0, 0);
        drive_cycle(1'b0, 0);
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 dut.u_props.failures);
        if (errors == 0 && dut.u_props.failures == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // 20 cycles per table entry plus the reset cycles
    initial begin
        wait (table_built);
        repeat (entries.size() * 20 + 5) @(posedge clock);
        $display("Timeout: run still busy at %0.0f ns, results missing", $realtime);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* alu_exec_cluster.f */
rtl/rv32_isa_pkg.sv
rtl/exec_pkg.sv
rtl/exec_ifs.sv
rtl/alu.sv
rtl/branch_condition.sv
rtl/alu_fu.sv
rtl/cdb_arbiter.sv
rtl/alu_exec_cluster.sv
verification/alu_exec_cluster_props.sv
verification/alu_exec_cluster_tb.sv

/* Bender.yml */
package:
  name: alu_exec_cluster

sources:
  - files:
      - rtl/rv32_isa_pkg.sv
      - rtl/exec_pkg.sv
      - rtl/exec_ifs.sv
      - rtl/alu.sv
      - rtl/branch_condition.sv
      - rtl/alu_fu.sv
      - rtl/cdb_arbiter.sv
      - rtl/alu_exec_cluster.sv
  - target: test
    files:
      - verification/alu_exec_cluster_props.sv
      - verification/alu_exec_cluster_tb.sv
